// File: id_pkg.sv
package id_pkg;

    // 1RI20 major opcodes, inst[31:25]
    localparam logic [6:0] opc_lu12i     = 7'b0001010;
    localparam logic [6:0] opc_pcaddu12i = 7'b0001110;

    // 2RI12 opcodes, inst[31:22]
    localparam logic [9:0] opc_slti  = 10'b0000001000;
    localparam logic [9:0] opc_sltui = 10'b0000001001;
    localparam logic [9:0] opc_addi  = 10'b0000001010;
    localparam logic [9:0] opc_andi  = 10'b0000001101;
    localparam logic [9:0] opc_ori   = 10'b0000001110;
    localparam logic [9:0] opc_xori  = 10'b0000001111;

    localparam logic [6:0] exc_ine = 7'h0d; // instruction not exist

    typedef enum logic [7:0] {
        alu_nop       = 8'd0,
        alu_lu12i     = 8'd1,
        alu_pcaddu12i = 8'd2,
        alu_slt       = 8'd3,
        alu_sltu      = 8'd4,
        alu_add       = 8'd5,
        alu_and       = 8'd6,
        alu_or        = 8'd7,
        alu_xor       = 8'd8
    } alu_op_e;

    typedef enum logic [2:0] {
        sel_nop   = 3'd0,
        sel_arith = 3'd1,
        sel_logic = 3'd2
    } alu_sel_e;

    typedef logic [4:0] reg_addr_t;

    // exception raised upstream in fetch
    typedef struct packed {
        logic       flag;
        logic [6:0] cause;
    } fetch_exc_t;

    typedef struct packed {
        logic      valid;          // format matched
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        logic      reg1_read_en;
        reg_addr_t reg1_read_addr;
        logic      reg2_read_en;
        alu_op_e   alu_op;
        alu_sel_e  alu_sel;
        logic [31:0] imm;
    } decode_t;

    localparam decode_t decode_nop = '{
        valid:          1'b0,
        reg_write_en:   1'b0,
        reg_write_addr: 5'd0,
        reg1_read_en:   1'b0,
        reg1_read_addr: 5'd0,
        reg2_read_en:   1'b0,
        alu_op:         alu_nop,
        alu_sel:        sel_nop,
        imm:            32'h0
    };

    // one ID pipeline record
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        fetch_exc_t  exc;
        decode_t     dec;
    } id_out_t;

endpackage

// File: id_1ri20.sv
`timescale 1ns/100ps

module id_1ri20 import id_pkg::*; (
    input  logic [31:0] inst,
    output decode_t     dec
);

    logic [6:0]  opcode;
    logic [19:0] si20;
    reg_addr_t   rd;

    assign opcode = inst[31:25];
    assign si20   = inst[24:5];
    assign rd     = inst[4:0];

    always_comb begin
        dec = decode_nop;
        case (opcode)
            opc_lu12i: begin
                dec.valid          = 1'b1;
                dec.reg_write_en   = 1'b1;
                dec.reg_write_addr = rd;
                dec.alu_op         = alu_lu12i;
                dec.alu_sel        = sel_arith;
                dec.imm            = {si20, 12'b0}; // upper 20 bits
            end
            opc_pcaddu12i: begin
                dec.valid          = 1'b1;
                dec.reg_write_en   = 1'b1;
                dec.reg_write_addr = rd;
                dec.alu_op         = alu_pcaddu12i;
                dec.alu_sel        = sel_arith;
                dec.imm            = {si20, 12'b0}; // added to pc in ex
            end
            default: begin
                dec = decode_nop;
            end
        endcase
        // no source registers in this format
        dec.reg1_read_en   = 1'b0;
        dec.reg1_read_addr = 5'd0;
        dec.reg2_read_en   = 1'b0;
    end

endmodule

// File: id_2ri12.sv
`timescale 1ns/100ps

module id_2ri12 import id_pkg::*; (
    input  logic [31:0] inst,
    output decode_t     dec
);

    logic [9:0]  opcode;
    logic [11:0] imm12;
    reg_addr_t   rj;
    reg_addr_t   rd;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;

    assign opcode = inst[31:22];
    assign imm12  = inst[21:10];
    assign rj     = inst[9:5];
    assign rd     = inst[4:0];

    assign imm_sext = {{20{imm12[11]}}, imm12}; // arithmetic group
    assign imm_zext = {20'b0, imm12};           // logic group

    always_comb begin
        dec = decode_nop;
        case (opcode)
            opc_slti: begin
                dec.valid   = 1'b1;
                dec.alu_op  = alu_slt;
                dec.alu_sel = sel_arith;
                dec.imm     = imm_sext;
            end
            opc_sltui: begin
                dec.valid   = 1'b1;
                dec.alu_op  = alu_sltu;
                dec.alu_sel = sel_arith;
                dec.imm     = imm_sext; // still sign extended, compare unsigned
            end
            opc_addi: begin
                dec.valid   = 1'b1;
                dec.alu_op  = alu_add;
                dec.alu_sel = sel_arith;
                dec.imm     = imm_sext;
            end
            opc_andi: begin
                dec.valid   = 1'b1;
                dec.alu_op  = alu_and;
                dec.alu_sel = sel_logic;
                dec.imm     = imm_zext;
            end
            opc_ori: begin
                dec.valid   = 1'b1;
                dec.alu_op  = alu_or;
                dec.alu_sel = sel_logic;
                dec.imm     = imm_zext;
            end
            opc_xori: begin
                dec.valid   = 1'b1;
                dec.alu_op  = alu_xor;
                dec.alu_sel = sel_logic;
                dec.imm     = imm_zext;
            end
            default: begin
                dec = decode_nop;
            end
        endcase

        // register fields common to the whole group
        if (dec.valid) begin
            dec.reg_write_en   = 1'b1;
            dec.reg_write_addr = rd;
            dec.reg1_read_en   = 1'b1;
            dec.reg1_read_addr = rj;
            dec.reg2_read_en   = 1'b0;
        end
    end

endmodule

// File: id_select.sv
`timescale 1ns/100ps

module id_select import id_pkg::*; (
    input  logic        in_valid,
    input  logic [31:0] pc,
    input  logic [31:0] inst,
    input  fetch_exc_t  fetch_exc,
    input  decode_t     dec_1ri20,
    input  decode_t     dec_2ri12,
    output id_out_t     rec
);

    always_comb begin
        rec = '0;
        if (in_valid) begin
            rec.valid = 1'b1;
            rec.pc    = pc;
            rec.inst  = inst;

            if (fetch_exc.flag) begin
                rec.exc = fetch_exc; // fetch cause wins
                rec.dec = decode_nop;
            end else if (dec_1ri20.valid) begin
                rec.exc = '0;
                rec.dec = dec_1ri20;
            end else if (dec_2ri12.valid) begin
                rec.exc = '0;
                rec.dec = dec_2ri12;
            end else begin
                // no format claimed the word
                rec.exc.flag  = 1'b1;
                rec.exc.cause = exc_ine;
                rec.dec       = decode_nop;
            end
        end
    end

endmodule

// File: id_stage.sv
`timescale 1ns/100ps

module id_stage import id_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [31:0] pc,
    input  logic [31:0] inst,
    input  fetch_exc_t  fetch_exc,
    output id_out_t     out
);

    decode_t dec_1ri20;
    decode_t dec_2ri12;
    id_out_t rec;

    // both format decoders look at the same word
    id_1ri20 id_1ri20_inst (
        .inst (inst),
        .dec  (dec_1ri20)
    );

    id_2ri12 id_2ri12_inst (
        .inst (inst),
        .dec  (dec_2ri12)
    );

    id_select id_select_inst (
        .in_valid  (in_valid),
        .pc        (pc),
        .inst      (inst),
        .fetch_exc (fetch_exc),
        .dec_1ri20 (dec_1ri20),
        .dec_2ri12 (dec_2ri12),
        .rec       (rec)
    );

    // ID pipeline register, loads every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            out <= '0;
        end else begin
            out <= rec; // bubble arrives as all zeros
        end
    end

endmodule

// File: tb_id_stage.sv
`timescale 1ns/100ps

module tb_id_stage import id_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic [31:0] pc;
    logic [31:0] inst;
    fetch_exc_t  fetch_exc;
    id_out_t     out;

    logic [31:0] rng;
    id_out_t     exp_q[$];   // one expectation for the record in flight
    id_out_t     exp_now;

    id_stage id_stage_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .pc        (pc),
        .inst      (inst),
        .fetch_exc (fetch_exc),
        .out       (out)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected ID record for one set of inputs
    function automatic id_out_t expected_rec(input logic v, input logic [31:0] pc_i,
                                             input logic [31:0] inst_i, input fetch_exc_t fe);
        id_out_t r;
        decode_t d;
        logic    known;
        logic    sext;
        r     = '0;
        d     = '0;
        known = 1'b0;
        sext  = 1'b0;
        if (inst_i[31:25] == opc_lu12i || inst_i[31:25] == opc_pcaddu12i) begin
            known            = 1'b1;
            d.valid          = 1'b1;
            d.reg_write_en   = 1'b1;
            d.reg_write_addr = inst_i[4:0];
            d.alu_op         = (inst_i[31:25] == opc_lu12i) ? alu_lu12i : alu_pcaddu12i;
            d.alu_sel        = sel_arith;
            d.imm            = {inst_i[24:5], 12'h000}; // si20 << 12
        end else begin
            known = 1'b1;
            case (inst_i[31:22])
                opc_slti:  begin d.alu_op = alu_slt;  sext = 1'b1; end
                opc_sltui: begin d.alu_op = alu_sltu; sext = 1'b1; end
                opc_addi:  begin d.alu_op = alu_add;  sext = 1'b1; end
                opc_andi:  d.alu_op = alu_and;
                opc_ori:   d.alu_op = alu_or;
                opc_xori:  d.alu_op = alu_xor;
                default:   known = 1'b0;
            endcase
            if (known) begin
                d.valid          = 1'b1;
                d.reg_write_en   = 1'b1;
                d.reg_write_addr = inst_i[4:0];
                d.reg1_read_en   = 1'b1;
                d.reg1_read_addr = inst_i[9:5];
                d.alu_sel        = sext ? sel_arith : sel_logic;
                d.imm            = sext ? {{20{inst_i[21]}}, inst_i[21:10]}
                                        : {20'h0, inst_i[21:10]};
            end
        end
        if (v) begin
            r.valid = 1'b1;
            r.pc    = pc_i;
            r.inst  = inst_i;
            if (fe.flag) begin
                r.exc = fe; // dec stays all zero
            end else if (known) begin
                r.dec = d;
            end else begin
                r.exc.flag  = 1'b1;
                r.exc.cause = 7'h0d;
            end
        end
        return r;
    endfunction

    task automatic compare_field(input string name, input logic [135:0] got,
                                 input logic [135:0] want);
        if (got !== want) begin
            $display("mismatch at %0t ns: field %s got %h expected %h", $time, name, got, want);
            $display(">>> FAIL");
            $fatal(1, "output record differs from expected");
        end
    endtask

    task automatic drive_random();
        logic [31:0] sel;
        logic [31:0] fields;
        rng    = lcg_next(rng);
        sel    = rng;
        rng    = lcg_next(rng);
        fields = rng;
        rng    = lcg_next(rng);
        pc     = {rng[31:2], 2'b00};
        if (!sel[31]) begin // one of the known opcodes
            case (sel[30:28])
                3'd0: inst = {opc_lu12i, fields[24:0]};
                3'd1: inst = {opc_pcaddu12i, fields[24:0]};
                3'd2: inst = {opc_slti, fields[21:0]};
                3'd3: inst = {opc_sltui, fields[21:0]};
                3'd4: inst = {opc_addi, fields[21:0]};
                3'd5: inst = {opc_andi, fields[21:0]};
                3'd6: inst = {opc_ori, fields[21:0]};
                3'd7: inst = {opc_xori, fields[21:0]};
            endcase
        end else begin
            inst = fields;
        end
        in_valid        = (sel[27:24] != 4'd0);
        fetch_exc.flag  = (sel[23:20] == 4'd0);
        fetch_exc.cause = sel[19:13];
    endtask

    // out still holds the record of the previous edge here
    always @(posedge clk) begin
        if (reset) begin
            exp_q.delete();
            exp_q.push_back(id_out_t'(0)); // cleared register
        end else begin
            if (exp_q.size() != 0) begin
                exp_now = exp_q.pop_front();
                compare_field("valid", 136'(out.valid), 136'(exp_now.valid));
                compare_field("pc", 136'(out.pc), 136'(exp_now.pc));
                compare_field("inst", 136'(out.inst), 136'(exp_now.inst));
                compare_field("exc", 136'(out.exc), 136'(exp_now.exc));
                compare_field("dec", 136'(out.dec), 136'(exp_now.dec));
            end
            exp_q.push_back(expected_rec(in_valid, pc, inst, fetch_exc));
        end
    end

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

    initial begin
        int wait_cycles;
        in_valid    = 1'b0;
        pc          = 32'h0;
        inst        = 32'h0;
        fetch_exc   = '0;
        rng         = 32'hab37_d398;
        wait_cycles = 0;
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > 20) begin
                $display(">>> FAIL");
                $fatal(1, "reset was never released");
            end
        end
        for (int i = 0; i < 2000; i++) begin
            drive_random();
            @(negedge clk);
        end
        in_valid = 1'b0;
        repeat (3) @(negedge clk); // drain the last record
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: id_stage.f
id_pkg.sv
id_1ri20.sv
id_2ri12.sv
id_select.sv
id_stage.sv
tb_id_stage.sv

// File: run.sh
#!/bin/sh
# build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --timescale 1ns/100ps \
    --top-module tb_id_stage -f id_stage.f \
    --Mdir obj_dir -o sim_id_stage
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_id_stage
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
